// ==== verilog/switch_pkg.sv ====
package switch_pkg;

    localparam int WORD_W        = 16;
    localparam int NUM_PORTS     = 4;
    localparam int PAGE_WORDS    = 8;
    localparam int NUM_PAGES     = 64;
    localparam int MAX_PKT_WORDS = 64;
    localparam int MAX_PKT_PAGES = MAX_PKT_WORDS / PAGE_WORDS;

    typedef logic [WORD_W-1:0]                       word_t;
    typedef logic [$clog2(NUM_PORTS)-1:0]            port_t;
    typedef logic [$clog2(NUM_PAGES)-1:0]            page_t;
    typedef logic [$clog2(PAGE_WORDS)-1:0]           offset_t;
    typedef logic [$clog2(NUM_PAGES*PAGE_WORDS)-1:0] sram_addr_t;
    typedef logic [$clog2(MAX_PKT_WORDS+1)-1:0]      len_t;

    // first word of a packet, dest in the low bits
    typedef union packed {
        word_t raw;
        struct packed {
            logic [WORD_W-$bits(len_t)-$bits(port_t)-1:0] spare;
            len_t  length;
            port_t dest;
        } hdr;
    } pkt_word_u;

endpackage

// ==== verilog/packet_sram.sv ====
`timescale 1ns/1ps

module packet_sram (
    input  logic                   clk,
    input  logic                   wr_en,
    input  switch_pkg::sram_addr_t wr_addr,
    input  switch_pkg::word_t      wr_data,
    input  switch_pkg::sram_addr_t rd_addr,
    output switch_pkg::word_t      rd_data
);

    import switch_pkg::*;

    word_t mem [NUM_PAGES*PAGE_WORDS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // asynchronous read, reader needs no pipeline
    assign rd_data = mem[rd_addr];

endmodule

// ==== verilog/page_pool.sv ====
`timescale 1ns/1ps

module page_pool (
    input  logic              clk,
    input  logic              reset,
    input  logic              alloc,
    output switch_pkg::page_t free_page,
    input  logic              free_en,
    input  switch_pkg::page_t free_page_in,
    output logic [6:0]        free_count,
    output logic              full
);

    import switch_pkg::*;

    page_t list [NUM_PAGES];
    page_t rd_ptr;
    page_t wr_ptr;

    // list depth equals page count, so pointers just wrap
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
        end else begin
            if (alloc) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (free_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    // every page starts out free
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_PAGES; i++) begin
                list[i] <= page_t'(i);
            end
        end else if (free_en) begin
            list[wr_ptr] <= free_page_in;
        end
    end

    // full keeps one maximum packet in reserve
    always_ff @(posedge clk) begin
        if (reset) begin
            free_count <= 7'(NUM_PAGES);
            full       <= 1'b0;
        end else begin
            free_count <= free_count - 7'(alloc) + 7'(free_en);
            full       <= free_count < 7'(MAX_PKT_PAGES);
        end
    end

    assign free_page = list[rd_ptr];

endmodule

// ==== verilog/packet_queues.sv ====
`timescale 1ns/1ps

module packet_queues (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         link_en,
    input  switch_pkg::page_t                            link_from,
    input  switch_pkg::page_t                            link_to,
    input  logic                                         enq_en,
    input  switch_pkg::port_t                            enq_dest,
    input  switch_pkg::page_t                            enq_head,
    input  switch_pkg::page_t                            enq_tail,
    input  logic                                         deq_en,
    input  switch_pkg::port_t                            deq_dest,
    input  switch_pkg::page_t                            deq_next_head,
    input  switch_pkg::page_t                            jump_addr,
    output switch_pkg::page_t                            jump_next,
    output switch_pkg::page_t [switch_pkg::NUM_PORTS-1:0] queue_head,
    output logic [switch_pkg::NUM_PORTS-1:0][6:0]        queue_count
);

    import switch_pkg::*;

    page_t                jump [NUM_PAGES];
    page_t                queue_tail [NUM_PORTS];
    logic [NUM_PORTS-1:0] enq_hit;
    logic [NUM_PORTS-1:0] deq_hit;

    always_comb begin
        for (int q = 0; q < NUM_PORTS; q++) begin
            enq_hit[q] = enq_en && (enq_dest == port_t'(q));
            deq_hit[q] = deq_en && (deq_dest == port_t'(q));
        end
    end

    // page links inside a packet, and old tail to new head between packets
    always_ff @(posedge clk) begin
        if (link_en) begin
            jump[link_from] <= link_to;
        end
        if (enq_en && queue_count[enq_dest] != '0) begin
            jump[queue_tail[enq_dest]] <= enq_head;
        end
    end

    assign jump_next = jump[jump_addr];

    always_ff @(posedge clk) begin
        if (reset) begin
            queue_head  <= '0;
            queue_count <= '0;
        end else begin
            for (int q = 0; q < NUM_PORTS; q++) begin
                // queue empty, or its only packet leaves this cycle
                if (enq_hit[q] && (queue_count[q] == '0 ||
                                   (deq_hit[q] && queue_count[q] == 7'd1))) begin
                    queue_head[q] <= enq_head;
                end else if (deq_hit[q]) begin
                    queue_head[q] <= deq_next_head;
                end
                queue_count[q] <= queue_count[q] + 7'(enq_hit[q]) - 7'(deq_hit[q]);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int q = 0; q < NUM_PORTS; q++) begin
            if (enq_hit[q]) begin
                queue_tail[q] <= enq_tail;
            end
        end
    end

endmodule

// ==== verilog/write_ctrl.sv ====
`timescale 1ns/1ps

module write_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   wr_sop,
    input  logic                   wr_eop,
    input  logic                   wr_vld,
    input  switch_pkg::word_t      wr_data,
    output logic                   alloc,
    input  switch_pkg::page_t      free_page,
    output logic                   wr_en,
    output switch_pkg::sram_addr_t wr_addr,
    output switch_pkg::word_t      wr_data_out,
    output logic                   link_en,
    output switch_pkg::page_t      link_from,
    output switch_pkg::page_t      link_to,
    output logic                   enq_en,
    output switch_pkg::port_t      enq_dest,
    output switch_pkg::page_t      enq_head,
    output switch_pkg::page_t      enq_tail
);

    import switch_pkg::*;

    pkt_word_u in_word;
    port_t     cur_dest;
    page_t     first_page;
    page_t     cur_page;
    offset_t   next_offset;
    offset_t   word_offset;
    page_t     word_page;
    port_t     word_dest;
    page_t     word_first;

    assign in_word = wr_data;

    // header always opens a fresh page
    assign word_offset = wr_sop ? '0 : next_offset;
    assign alloc       = wr_vld && (word_offset == '0);
    assign word_page   = alloc ? free_page : cur_page;
    assign word_dest   = wr_sop ? in_word.hdr.dest : cur_dest;
    assign word_first  = wr_sop ? free_page : first_page;

    always_ff @(posedge clk) begin
        if (reset) begin
            next_offset <= '0;
            wr_en       <= 1'b0;
            link_en     <= 1'b0;
            enq_en      <= 1'b0;
        end else begin
            wr_en   <= wr_vld;
            link_en <= alloc && !wr_sop;
            enq_en  <= wr_vld && wr_eop;
            if (wr_vld) begin
                next_offset <= word_offset + 1'b1;
            end
        end
    end

    // enq fields hold the eop word's values for one cycle
    always_ff @(posedge clk) begin
        if (wr_vld) begin
            cur_page    <= word_page;
            cur_dest    <= word_dest;
            first_page  <= word_first;
            wr_addr     <= {word_page, word_offset};
            wr_data_out <= wr_data;
            link_from   <= cur_page;
            link_to     <= free_page;
            enq_dest    <= word_dest;
            enq_head    <= word_first;
            enq_tail    <= word_page;
        end
    end

endmodule

// ==== verilog/read_ctrl.sv ====
`timescale 1ns/1ps

module read_ctrl (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic [switch_pkg::NUM_PORTS-1:0]             ready,
    input  switch_pkg::page_t [switch_pkg::NUM_PORTS-1:0] queue_head,
    input  logic [switch_pkg::NUM_PORTS-1:0][6:0]        queue_count,
    output switch_pkg::page_t                            jump_addr,
    input  switch_pkg::page_t                            jump_next,
    output switch_pkg::sram_addr_t                       rd_addr,
    input  switch_pkg::word_t                            rd_data,
    output logic                                         deq_en,
    output switch_pkg::port_t                            deq_dest,
    output switch_pkg::page_t                            deq_next_head,
    output logic                                         free_en,
    output switch_pkg::page_t                            free_page_in,
    output logic [switch_pkg::NUM_PORTS-1:0]             rd_sop,
    output logic [switch_pkg::NUM_PORTS-1:0]             rd_eop,
    output logic [switch_pkg::NUM_PORTS-1:0]             rd_vld,
    output switch_pkg::word_t [switch_pkg::NUM_PORTS-1:0] rd_data_out
);

    import switch_pkg::*;

    pkt_word_u out_word;
    logic      busy;
    logic      first;
    port_t     cur_port;
    port_t     rr_last;
    page_t     cur_page;
    offset_t   cur_offset;
    len_t      pkt_len;
    len_t      word_cnt;
    len_t      len_now;
    logic      emit;
    logic      last;
    logic      pick_vld;
    port_t     pick_port;

    assign out_word  = rd_data;
    assign rd_addr   = {cur_page, cur_offset};
    assign jump_addr = cur_page;

    // header carries the length of its own packet
    assign len_now = first ? out_word.hdr.length : pkt_len;
    assign emit    = busy && ready[cur_port];
    assign last    = (word_cnt == len_now - 1'b1);

    assign deq_en        = emit && last;
    assign deq_dest      = cur_port;
    assign deq_next_head = jump_next;
    // page done after its eighth word or at packet end
    assign free_en       = emit && (last || cur_offset == offset_t'(PAGE_WORDS - 1));
    assign free_page_in  = cur_page;

    // search starts just after the last served port
    always_comb begin
        port_t cand;
        pick_vld  = 1'b0;
        pick_port = rr_last;
        for (int i = NUM_PORTS; i >= 1; i--) begin
            cand = rr_last + port_t'(i);
            if (queue_count[cand] != '0 && ready[cand]) begin
                pick_vld  = 1'b1;
                pick_port = cand;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy        <= 1'b0;
            rr_last     <= '0;
            rd_sop      <= '0;
            rd_eop      <= '0;
            rd_vld      <= '0;
            rd_data_out <= '0;
        end else begin
            rd_sop <= '0;
            rd_eop <= '0;
            rd_vld <= '0;
            if (emit) begin
                rd_vld[cur_port]      <= 1'b1;
                rd_sop[cur_port]      <= first;
                rd_eop[cur_port]      <= last;
                rd_data_out[cur_port] <= out_word.raw;
                if (last) begin
                    busy <= 1'b0;
                end
            end else if (!busy && pick_vld) begin
                busy    <= 1'b1;
                rr_last <= pick_port;
            end
        end
    end

    // position in the packet, held while ready is low
    always_ff @(posedge clk) begin
        if (!busy && pick_vld) begin
            cur_port   <= pick_port;
            cur_page   <= queue_head[pick_port];
            cur_offset <= '0;
            word_cnt   <= '0;
            first      <= 1'b1;
        end else if (emit) begin
            first      <= 1'b0;
            word_cnt   <= word_cnt + 1'b1;
            cur_offset <= cur_offset + 1'b1;
            if (first) begin
                pkt_len <= out_word.hdr.length;
            end
            if (cur_offset == offset_t'(PAGE_WORDS - 1)) begin
                cur_page <= jump_next;
            end
        end
    end

endmodule

// ==== verilog/switch_top.sv ====
`timescale 1ns/1ps

module switch_top (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         wr_sop,
    input  logic                                         wr_eop,
    input  logic                                         wr_vld,
    input  switch_pkg::word_t                            wr_data,
    output logic                                         full,
    input  logic [switch_pkg::NUM_PORTS-1:0]             ready,
    output logic [switch_pkg::NUM_PORTS-1:0]             rd_sop,
    output logic [switch_pkg::NUM_PORTS-1:0]             rd_eop,
    output logic [switch_pkg::NUM_PORTS-1:0]             rd_vld,
    output switch_pkg::word_t [switch_pkg::NUM_PORTS-1:0] rd_data
);

    import switch_pkg::*;

    logic                         alloc, free_en, sram_wr_en, link_en, enq_en, deq_en;
    page_t                        free_page, free_page_in, link_from, link_to;
    page_t                        enq_head, enq_tail, deq_next_head, jump_addr, jump_next;
    port_t                        enq_dest, deq_dest;
    sram_addr_t                   sram_wr_addr, sram_rd_addr;
    word_t                        sram_wr_data, sram_rd_data;
    page_t [NUM_PORTS-1:0]        queue_head;
    logic [NUM_PORTS-1:0][6:0]    queue_count;

    page_pool u_pool (.clk, .reset, .alloc, .free_page, .free_en, .free_page_in,
        .free_count(), .full);

    packet_sram u_sram (.clk, .wr_en(sram_wr_en), .wr_addr(sram_wr_addr),
        .wr_data(sram_wr_data), .rd_addr(sram_rd_addr), .rd_data(sram_rd_data));

    packet_queues u_queues (.clk, .reset, .link_en, .link_from, .link_to,
        .enq_en, .enq_dest, .enq_head, .enq_tail, .deq_en, .deq_dest, .deq_next_head,
        .jump_addr, .jump_next, .queue_head, .queue_count);

    write_ctrl u_write (.clk, .reset, .wr_sop, .wr_eop, .wr_vld, .wr_data,
        .alloc, .free_page, .wr_en(sram_wr_en), .wr_addr(sram_wr_addr),
        .wr_data_out(sram_wr_data), .link_en, .link_from, .link_to,
        .enq_en, .enq_dest, .enq_head, .enq_tail);

    read_ctrl u_read (.clk, .reset, .ready, .queue_head, .queue_count,
        .jump_addr, .jump_next, .rd_addr(sram_rd_addr), .rd_data(sram_rd_data),
        .deq_en, .deq_dest, .deq_next_head, .free_en, .free_page_in,
        .rd_sop, .rd_eop, .rd_vld, .rd_data_out(rd_data));

endmodule

// ==== verif/switch_properties.sv ====
`timescale 1ns/1ps

module switch_properties (
    input logic                                         clk,
    input logic                                         reset,
    input logic [switch_pkg::NUM_PORTS-1:0]             rd_sop,
    input logic [switch_pkg::NUM_PORTS-1:0]             rd_eop,
    input logic [switch_pkg::NUM_PORTS-1:0]             rd_vld,
    input switch_pkg::word_t [switch_pkg::NUM_PORTS-1:0] rd_data
);

    // one reader, so at most one port carries a word
    vld_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(rd_vld))
        else $error("more than one rd_vld bit high in one cycle");

    // outputs come out of reset cleared
    quiet_in_reset: assert property (@(posedge clk)
        reset |=> (rd_vld == '0 && rd_sop == '0 && rd_eop == '0 && rd_data == '0))
        else $error("rd outputs not cleared by reset");

    eop_with_vld: assert property (@(posedge clk) disable iff (reset)
        (rd_eop & ~rd_vld) == '0)
        else $error("rd_eop high on a port without rd_vld");

endmodule

bind switch_top switch_properties props0 (.clk, .reset, .rd_sop, .rd_eop, .rd_vld, .rd_data);

// ==== verif/tb_switch.sv ====
`timescale 1ns/1ps

module tb_switch;

    import switch_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int MAX_TESTS  = 16;
    localparam int MARGIN_NS  = 20000;

    logic                  clk;
    logic                  reset;
    logic                  wr_sop;
    logic                  wr_eop;
    logic                  wr_vld;
    word_t                 wr_data;
    logic                  full;
    logic [NUM_PORTS-1:0]  ready;
    logic [NUM_PORTS-1:0]  rd_sop;
    logic [NUM_PORTS-1:0]  rd_eop;
    logic [NUM_PORTS-1:0]  rd_vld;
    word_t [NUM_PORTS-1:0] rd_data;

    // expected {sop, eop, data} per port, with the test each word belongs to
    logic [WORD_W+1:0] exp_q [NUM_PORTS][$];
    int                exp_t [NUM_PORTS][$];
    int                pkt_test [$];
    int                pkt_dest [$];
    int                pkt_len [$];
    int                pkt_hold [$];
    word_t             pkt_base [$];
    string             test_names [MAX_TESTS];
    int                test_left [MAX_TESTS];
    int                test_errs [MAX_TESTS];
    int                num_tests;
    int                total_words;
    int                errors;
    int                checks;
    logic              loaded;
    logic              full_seen;
    logic [31:0]       rnd;

    switch_top dut0 (.clk, .reset, .wr_sop, .wr_eop, .wr_vld, .wr_data, .full, .ready,
        .rd_sop, .rd_eop, .rd_vld, .rd_data);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int find_test(input string name);
        for (int i = 0; i < num_tests; i++) begin
            if (test_names[i] == name) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic logic queues_empty();
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (exp_q[p].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // next falling edge, fresh random ready, write port idle
    task automatic step_cycle(input logic hold);
        @(negedge clk);
        rnd    = xorshift32(rnd);
        ready  = hold ? '0 : (rnd[3:0] | rnd[7:4]);
        wr_vld = 1'b0;
        wr_sop = 1'b0;
        wr_eop = 1'b0;
    endtask

    task automatic load_packets();
        int          fd;
        int          n;
        int          ti;
        int          dest;
        int          len;
        int          hold;
        logic [15:0] base;
        string       line;
        string       name;
        fd = $fopen("verif/switch_golden.txt", "r");
        assert (fd != 0) else begin
            $display("could not open verif/switch_golden.txt");
            errors++;
        end
        while (fd != 0 && !$feof(fd)) begin
            n = $fgets(line, fd);
            if (n == 0 || line[0] == "#") begin
                continue;
            end
            if ($sscanf(line, "%s %d %d %h %d", name, dest, len, base, hold) != 5) begin
                continue;
            end
            ti = find_test(name);
            if (ti < 0) begin
                ti = num_tests;
                test_names[ti] = name;
                num_tests++;
            end
            test_left[ti] += len;
            total_words   += len;
            pkt_test.push_back(ti);
            pkt_dest.push_back(dest);
            pkt_len.push_back(len);
            pkt_hold.push_back(hold);
            pkt_base.push_back(base);
        end
        if (fd != 0) begin
            $fclose(fd);
        end
    endtask

    task automatic send_packet(input int k);
        pkt_word_u hdr;
        word_t     w;
        int        p;
        logic      hold;
        p    = pkt_dest[k];
        hold = (pkt_hold[k] != 0);
        // one idle cycle, then the header once full is low
        step_cycle(hold);
        step_cycle(hold);
        while (full) begin
            step_cycle(1'b0);
        end
        hdr.raw        = '0;
        hdr.hdr.dest   = port_t'(p);
        hdr.hdr.length = len_t'(pkt_len[k]);
        hdr.hdr.spare  = pkt_base[k][6:0];
        for (int i = 0; i < pkt_len[k]; i++) begin
            if (i > 0) begin
                step_cycle(hold);
            end
            w       = (i == 0) ? hdr.raw : word_t'(pkt_base[k] + i - 1);
            wr_vld  = 1'b1;
            wr_sop  = (i == 0);
            wr_eop  = (i == pkt_len[k] - 1);
            wr_data = w;
            exp_q[p].push_back({wr_sop, wr_eop, w});
            exp_t[p].push_back(pkt_test[k]);
        end
    endtask

    task automatic report_test(input int ti);
        if (test_errs[ti] == 0) begin
            $display("test %s passed", test_names[ti]);
        end else begin
            $display("test %s failed with %0d errors", test_names[ti], test_errs[ti]);
        end
    endtask

    // sop and eop flags, then the data word
    task automatic report_mismatch(input int ti, input int p,
                                   input logic [WORD_W+1:0] expected,
                                   input logic [WORD_W+1:0] actual);
        $display("[FAIL] %s port %0d: expected sop/eop/data %b/%b/%h, actual %b/%b/%h",
            test_names[ti], p, expected[WORD_W+1], expected[WORD_W], expected[WORD_W-1:0],
            actual[WORD_W+1], actual[WORD_W], actual[WORD_W-1:0]);
    endtask

    // outputs are registered, so mid-cycle they are stable
    always @(negedge clk) begin
        logic [WORD_W+1:0] expected;
        logic [WORD_W+1:0] actual;
        int                ti;
        if (reset === 1'b0) begin
            if (full) begin
                full_seen = 1'b1;
            end
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (rd_vld[p]) begin
                    actual = {rd_sop[p], rd_eop[p], rd_data[p]};
                    assert (exp_q[p].size() != 0) else begin
                        $display("port %0d put out a word that no sent packet holds", p);
                        errors++;
                    end
                    if (exp_q[p].size() != 0) begin
                        expected = exp_q[p].pop_front();
                        ti       = exp_t[p].pop_front();
                        checks++;
                        assert (actual == expected) else begin
                            report_mismatch(ti, p, expected, actual);
                            errors++;
                            test_errs[ti]++;
                        end
                        test_left[ti]--;
                        if (test_left[ti] == 0) begin
                            report_test(ti);
                        end
                    end
                end
            end
        end
    end

    // limit grows with the amount of traffic in the file
    initial begin
        wait (loaded === 1'b1);
        #(total_words * 40 * CLK_PERIOD + MARGIN_NS);
        $display("timeout: the switch did not deliver every packet in time");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        reset       = 1'b1;
        wr_sop      = 1'b0;
        wr_eop      = 1'b0;
        wr_vld      = 1'b0;
        wr_data     = '0;
        ready       = '0;
        errors      = 0;
        checks      = 0;
        num_tests   = 0;
        total_words = 0;
        full_seen   = 1'b0;
        loaded      = 1'b0;
        rnd         = 32'd39209;
        load_packets();
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int k = 0; k < pkt_test.size(); k++) begin
            send_packet(k);
        end
        step_cycle(1'b0);
        while (!queues_empty()) begin
            step_cycle(1'b0);
        end
        // returned pages reach full two cycles late
        repeat (4) step_cycle(1'b0);
        assert (!full) else begin
            $display("full still high after every packet was drained");
            errors++;
        end
        assert (full_seen) else begin
            $display("full never rose during the burst");
            errors++;
        end
        $display("%0d tests, %0d words checked, %0d errors", num_tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== build.f ====
verilog/switch_pkg.sv
verilog/packet_sram.sv
verilog/page_pool.sv
verilog/packet_queues.sv
verilog/write_ctrl.sv
verilog/read_ctrl.sv
verilog/switch_top.sv
verif/switch_properties.sv
verif/tb_switch.sv

// ==== verif/switch_golden.txt ====
# test  dest  length  first_payload_word(hex, later words count up)  hold
# hold 1 keeps every ready low while that packet is written
len2    1     2       1111    0
len8    2     8       2220    0
len9    3     9       3330    0
len64   0     64      4440    0
order   2     3       5000    0
order   2     11      5100    0
order   2     17      5200    0
burst   0     64      6000    1
burst   1     64      6100    1
burst   2     64      6200    1
burst   3     64      6300    1
burst   0     64      6400    1
burst   1     64      6500    1
burst   2     64      6600    1
burst   3     2       6700    1
after   1     12      7700    0
